// File: rtl/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// Datapath widths
`define XLEN 32
`define REG_ADDR_W 5

// Exception cause encoding, mcause numbering
`define ECAUSE_W 4
`define ECAUSE_ILLEGAL 2
`define ECAUSE_BREAKPOINT 3
`define ECAUSE_ECALL_M 11

`endif

// File: rtl/decode_pkg.sv
`include "decode_config.svh"

package decode_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`ECAUSE_W-1:0] ecause_t;

    // RV32I major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OPC_LUI      = 7'b0110111,
        OPC_AUIPC    = 7'b0010111,
        OPC_JAL      = 7'b1101111,
        OPC_JALR     = 7'b1100111,
        OPC_BRANCH   = 7'b1100011,
        OPC_LOAD     = 7'b0000011,
        OPC_STORE    = 7'b0100011,
        OPC_OP_IMM   = 7'b0010011,
        OPC_OP       = 7'b0110011,
        OPC_MISC_MEM = 7'b0001111,
        OPC_SYSTEM   = 7'b1110011
    } opcode_t;

    // Same encoding as funct3
    typedef enum logic [2:0] {
        ALU_ADD_SUB = 3'b000,
        ALU_SLL     = 3'b001,
        ALU_SLT     = 3'b010,
        ALU_SLTU    = 3'b011,
        ALU_XOR     = 3'b100,
        ALU_SRL_SRA = 3'b101,
        ALU_OR      = 3'b110,
        ALU_AND     = 3'b111
    } alu_func_t;

    typedef enum logic [1:0] {
        ALU_SEL_REG  = 2'b00,
        ALU_SEL_IMM  = 2'b01,
        ALU_SEL_PC   = 2'b10,
        ALU_SEL_ZERO = 2'b11
    } alu_sel_t;

    typedef enum logic [1:0] {
        WRITE_SEL_NONE    = 2'b00,
        WRITE_SEL_ALU     = 2'b01,
        WRITE_SEL_LOAD    = 2'b10,
        WRITE_SEL_NEXT_PC = 2'b11
    } write_sel_t;

    typedef struct packed {
        alu_func_t  alu_func;
        logic       alu_func_sel;    // SUB / SRA
        alu_sel_t   alu_a_sel;
        alu_sel_t   alu_b_sel;
        logic [1:0] reserved;        // Always zero
        logic       cmp_less;
        logic       cmp_sign;
        logic       cmp_negate;
        logic       jump;
        logic       branch;
    } ex_ctrl_t;

    typedef struct packed {
        logic       load;
        logic       store;
        logic [1:0] size;           // 0 byte, 1 half, 2 word
        logic       load_signed;
    } mem_ctrl_t;

    typedef struct packed {
        write_sel_t write_sel;
        reg_addr_t  rd_addr;
    } wb_ctrl_t;

    typedef struct packed {
        logic    exception;
        ecause_t ecause;
    } trap_t;

    typedef struct packed {
        ex_ctrl_t  ex;
        mem_ctrl_t mem;
        wb_ctrl_t  wb;
        trap_t     trap;
    } decode_ctrl_t;

endpackage

// File: rtl/imm_gen.sv
`timescale 1ns/10ps

module imm_gen
    import decode_pkg::*;
(
    input  xlen_t instr,
    output xlen_t imm
);

    opcode_t opcode;

    assign opcode = opcode_t'(instr[6:0]);

    always_comb begin
        case (opcode)
            OPC_LUI,
            OPC_AUIPC: begin
                imm = {instr[31:12], 12'b0};    // U-type
            end
            OPC_JAL: begin
                imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            end
            OPC_JALR,
            OPC_LOAD,
            OPC_OP_IMM: begin
                imm = {{20{instr[31]}}, instr[31:20]};    // I-type
            end
            OPC_STORE: begin
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};    // S-type
            end
            OPC_BRANCH: begin
                // B-type, imm[12] from instr[31] and imm[11] from instr[7]
                imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// File: rtl/ctrl_decode.sv
`timescale 1ns/10ps
`include "decode_config.svh"

module ctrl_decode
    import decode_pkg::*;
(
    input  xlen_t        instr,
    output decode_ctrl_t ctrl
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    logic       illegal;

    assign opcode = opcode_t'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];
    assign rd     = instr[11:7];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        ctrl    = '0;
        illegal = 1'b0;
        case (opcode)
            OPC_LUI: begin
                ctrl.ex.alu_func  = ALU_OR;    // 0 | imm
                ctrl.ex.alu_a_sel = ALU_SEL_ZERO;
                ctrl.ex.alu_b_sel = ALU_SEL_IMM;
                ctrl.wb.write_sel = WRITE_SEL_ALU;
                ctrl.wb.rd_addr   = rd;
            end
            OPC_AUIPC: begin
                ctrl.ex.alu_func  = ALU_ADD_SUB;
                ctrl.ex.alu_a_sel = ALU_SEL_PC;
                ctrl.ex.alu_b_sel = ALU_SEL_IMM;
                ctrl.wb.write_sel = WRITE_SEL_ALU;
                ctrl.wb.rd_addr   = rd;
            end
            OPC_JAL,
            OPC_JALR: begin
                ctrl.ex.alu_func  = ALU_ADD_SUB;    // Target address
                ctrl.ex.alu_a_sel = (opcode == OPC_JAL) ? ALU_SEL_PC : ALU_SEL_REG;
                ctrl.ex.alu_b_sel = ALU_SEL_IMM;
                ctrl.ex.branch    = 1'b1;
                ctrl.ex.jump      = 1'b1;
                ctrl.wb.write_sel = WRITE_SEL_NEXT_PC;    // Link value
                ctrl.wb.rd_addr   = rd;
                illegal           = (opcode == OPC_JALR) && (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                ctrl.ex.alu_func   = ALU_ADD_SUB;
                ctrl.ex.alu_a_sel  = ALU_SEL_PC;
                ctrl.ex.alu_b_sel  = ALU_SEL_IMM;
                ctrl.ex.branch     = 1'b1;
                ctrl.ex.cmp_less   = funct3[2];
                ctrl.ex.cmp_sign   = funct3[1];    // Set for unsigned compares
                ctrl.ex.cmp_negate = funct3[0];
                illegal            = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD: begin
                ctrl.ex.alu_func     = ALU_ADD_SUB;
                ctrl.ex.alu_a_sel    = ALU_SEL_REG;
                ctrl.ex.alu_b_sel    = ALU_SEL_IMM;
                ctrl.mem.load        = 1'b1;
                ctrl.mem.size        = funct3[1:0];
                ctrl.mem.load_signed = !funct3[2];
                ctrl.wb.write_sel    = WRITE_SEL_LOAD;
                ctrl.wb.rd_addr      = rd;
                // No double word, no LWU on RV32
                illegal = (funct3[1:0] == 2'b11) || (funct3 == 3'b110);
            end
            OPC_STORE: begin
                ctrl.ex.alu_func  = ALU_ADD_SUB;
                ctrl.ex.alu_a_sel = ALU_SEL_REG;
                ctrl.ex.alu_b_sel = ALU_SEL_IMM;
                ctrl.mem.store    = 1'b1;
                ctrl.mem.size     = funct3[1:0];
                illegal           = (funct3[1:0] == 2'b11) || funct3[2];
            end
            OPC_OP_IMM: begin
                ctrl.ex.alu_func     = alu_func_t'(funct3);
                ctrl.ex.alu_func_sel = (funct3 == ALU_SRL_SRA) && instr[30];    // SRAI
                ctrl.ex.alu_a_sel    = ALU_SEL_REG;
                ctrl.ex.alu_b_sel    = ALU_SEL_IMM;
                ctrl.wb.write_sel    = WRITE_SEL_ALU;
                ctrl.wb.rd_addr      = rd;
            end
            OPC_OP: begin
                ctrl.ex.alu_func     = alu_func_t'(funct3);
                ctrl.ex.alu_func_sel = instr[30];
                ctrl.ex.alu_a_sel    = ALU_SEL_REG;
                ctrl.ex.alu_b_sel    = ALU_SEL_REG;
                ctrl.wb.write_sel    = WRITE_SEL_ALU;
                ctrl.wb.rd_addr      = rd;
                // Only SUB and SRA use the alternate funct7
                illegal = (funct7 != 7'b0000000) &&
                          ((funct7 != 7'b0100000) ||
                           ((funct3 != 3'b000) && (funct3 != 3'b101)));
            end
            OPC_MISC_MEM: begin
                illegal = (funct3 != 3'b000);    // FENCE is a no-op here
            end
            OPC_SYSTEM: begin
                if ((funct3 != 3'b000) || (rs1 != '0) || (rd != '0) ||
                    (funct7 != 7'b0000000)) begin
                    illegal = 1'b1;
                end else if (rs2 == 5'd0) begin
                    ctrl.trap.exception = 1'b1;
                    ctrl.trap.ecause    = ecause_t'(`ECAUSE_ECALL_M);
                end else if (rs2 == 5'd1) begin
                    ctrl.trap.exception = 1'b1;
                    ctrl.trap.ecause    = ecause_t'(`ECAUSE_BREAKPOINT);
                end else begin
                    illegal = 1'b1;    // MRET, WFI and the rest
                end
            end
            default: begin
                illegal = 1'b1;
            end
        endcase

        // Illegal instruction carries only the trap
        if (illegal) begin
            ctrl                = '0;
            ctrl.trap.exception = 1'b1;
            ctrl.trap.ecause    = ecause_t'(`ECAUSE_ILLEGAL);
        end
    end

    always_comb begin
        assert (!(ctrl.mem.load && ctrl.mem.store))
            else $error("ctrl_decode: load and store both set, instr %h", instr);
    end

endmodule

// File: rtl/decode_stage.sv
`timescale 1ns/10ps

module decode_stage
    import decode_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,

    input  xlen_t        pc_in,
    input  xlen_t        next_pc_in,
    input  xlen_t        instr,
    input  logic         valid_in,

    input  logic         stall_in,
    input  logic         invalidate,
    input  reg_addr_t    data_hazard_0,
    input  reg_addr_t    data_hazard_1,

    output reg_addr_t    rs1_select,
    output reg_addr_t    rs2_select,
    input  xlen_t        rs1_data,
    input  xlen_t        rs2_data,

    output logic         stall_out,

    output xlen_t        pc_out,
    output xlen_t        next_pc_out,
    output xlen_t        data_rs1,
    output xlen_t        data_rs2,
    output xlen_t        data_imm,
    output decode_ctrl_t ctrl,
    output logic         valid_out
);

    xlen_t        imm_next;
    decode_ctrl_t ctrl_next;
    logic         hazard_0_hit;
    logic         hazard_1_hit;
    logic         accept;

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm_next)
    );

    ctrl_decode u_ctrl_decode (
        .instr (instr),
        .ctrl  (ctrl_next)
    );

    // Register file reads, taken from the raw fields whatever the format
    assign rs1_select = instr[19:15];
    assign rs2_select = instr[24:20];

    // x0 never creates a dependency
    assign hazard_0_hit = (data_hazard_0 != '0) &&
                          ((data_hazard_0 == rs1_select) || (data_hazard_0 == rs2_select));
    assign hazard_1_hit = (data_hazard_1 != '0) &&
                          ((data_hazard_1 == rs1_select) || (data_hazard_1 == rs2_select));
    assign stall_out    = hazard_0_hit || hazard_1_hit;

    assign accept = !stall_in && valid_in && !stall_out && !invalidate;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_out <= 1'b0;
            ctrl      <= '0;
        end else if (!stall_in) begin
            valid_out <= accept;    // Bubble when not accepted
            if (accept) begin
                ctrl <= ctrl_next;
            end
        end
    end

    // Payload, only meaningful with valid_out
    always_ff @(posedge clk) begin
        if (accept) begin
            pc_out      <= pc_in;
            next_pc_out <= next_pc_in;
            data_rs1    <= rs1_data;
            data_rs2    <= rs2_data;
            data_imm    <= imm_next;
        end
    end

    // Downstream back-pressure freezes the whole stage output
    assert property (@(posedge clk) disable iff (!rst_n)
        stall_in |=> $stable({pc_out, next_pc_out, data_rs1, data_rs2, data_imm,
                              ctrl, valid_out}))
        else $error("decode_stage: outputs changed under stall_in");

    assert property (@(posedge clk) disable iff (!rst_n)
        invalidate |=> !$rose(valid_out))
        else $error("decode_stage: valid_out rose after invalidate");

endmodule

// File: test/tb_decode.sv
`timescale 1ns/10ps

module tb_decode
    import decode_pkg::*;
;

    localparam int CLK_PERIOD   = 40;
    localparam int DRIVE_DELAY  = 2;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_VECTORS  = 44;
    localparam int FIELDS       = 15;    // Words per trace line

    logic         clk;
    logic         rst_n;
    xlen_t        pc_in;
    xlen_t        next_pc_in;
    xlen_t        instr;
    logic         valid_in;
    logic         stall_in;
    logic         invalidate;
    reg_addr_t    data_hazard_0;
    reg_addr_t    data_hazard_1;
    reg_addr_t    rs1_select;
    reg_addr_t    rs2_select;
    xlen_t        rs1_data;
    xlen_t        rs2_data;
    logic         stall_out;
    xlen_t        pc_out;
    xlen_t        next_pc_out;
    xlen_t        data_rs1;
    xlen_t        data_rs2;
    xlen_t        data_imm;
    decode_ctrl_t ctrl;
    logic         valid_out;

    logic [31:0]  trace_mem [0:NUM_VECTORS*FIELDS-1];

    // Payload of the last accepted instruction
    xlen_t        exp_pc;
    xlen_t        exp_next_pc;
    xlen_t        exp_rs1;
    xlen_t        exp_rs2;
    logic         payload_known;

    decode_stage uut (
        .clk           (clk),
        .rst_n         (rst_n),
        .pc_in         (pc_in),
        .next_pc_in    (next_pc_in),
        .instr         (instr),
        .valid_in      (valid_in),
        .stall_in      (stall_in),
        .invalidate    (invalidate),
        .data_hazard_0 (data_hazard_0),
        .data_hazard_1 (data_hazard_1),
        .rs1_select    (rs1_select),
        .rs2_select    (rs2_select),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .stall_out     (stall_out),
        .pc_out        (pc_out),
        .next_pc_out   (next_pc_out),
        .data_rs1      (data_rs1),
        .data_rs2      (data_rs2),
        .data_imm      (data_imm),
        .ctrl          (ctrl),
        .valid_out     (valid_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string name);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("** FAIL **");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    task automatic apply_vector(input int idx);
        int base;
        base          = idx * FIELDS;
        instr         = trace_mem[base];
        pc_in         = trace_mem[base + 1];
        next_pc_in    = trace_mem[base + 2];
        rs1_data      = trace_mem[base + 3];
        rs2_data      = trace_mem[base + 4];
        data_hazard_0 = trace_mem[base + 5][4:0];
        data_hazard_1 = trace_mem[base + 6][4:0];
        stall_in      = trace_mem[base + 7][0];
        invalidate    = trace_mem[base + 8][0];
        valid_in      = trace_mem[base + 9][0];
        // Accept rule of the pipeline register
        if (!stall_in && valid_in && !invalidate && !trace_mem[base + 10][0]) begin
            exp_pc        = pc_in;
            exp_next_pc   = next_pc_in;
            exp_rs1       = rs1_data;
            exp_rs2       = rs2_data;
            payload_known = 1'b1;
        end
    endtask

    task automatic check_registered(input int idx);
        int base;
        base = idx * FIELDS;
        check_value(32'(valid_out), trace_mem[base + 11], $sformatf("valid_out[%0d]", idx));
        if (payload_known) begin
            check_value(data_imm, trace_mem[base + 12], $sformatf("data_imm[%0d]", idx));
            check_value(pc_out, exp_pc, $sformatf("pc_out[%0d]", idx));
            check_value(next_pc_out, exp_next_pc, $sformatf("next_pc_out[%0d]", idx));
            check_value(data_rs1, exp_rs1, $sformatf("data_rs1[%0d]", idx));
            check_value(data_rs2, exp_rs2, $sformatf("data_rs2[%0d]", idx));
        end
        if (trace_mem[base + 14][0]) begin
            check_value(32'(ctrl), trace_mem[base + 13], $sformatf("ctrl[%0d]", idx));
        end
    endtask

    initial begin
        #((NUM_VECTORS + RESET_CYCLES) * 2 * CLK_PERIOD);
        $display("Simulation hung: trace did not complete within the time limit");
        $display("** FAIL **");
        $fatal(1, "Watchdog expired");
    end

    initial begin
        rst_n         = 1'b0;
        pc_in         = '0;
        next_pc_in    = '0;
        instr         = '0;
        valid_in      = 1'b0;
        stall_in      = 1'b0;
        invalidate    = 1'b0;
        data_hazard_0 = '0;
        data_hazard_1 = '0;
        rs1_data      = '0;
        rs2_data      = '0;
        exp_pc        = '0;
        exp_next_pc   = '0;
        exp_rs1       = '0;
        exp_rs2       = '0;
        payload_known = 1'b0;

        $readmemh("test/decode_trace.txt", trace_mem);
        if (^trace_mem[NUM_VECTORS*FIELDS-1] === 1'bx) begin
            $display("Trace file is missing or shorter than expected");
            $display("** FAIL **");
            $fatal(1, "Bad trace file");
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b1;
        check_value(32'(valid_out), 32'd0, "valid_out after reset");
        check_value(32'(ctrl), 32'd0, "ctrl after reset");

        for (int i = 0; i < NUM_VECTORS; i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (i > 0) begin
                check_registered(i - 1);    // Result of the previous line
            end
            apply_vector(i);
            #1;
            check_value(32'(stall_out), trace_mem[i*FIELDS + 10], $sformatf("stall_out[%0d]", i));
            // Register file selects are the rs1 and rs2 fields of the word
            check_value(32'(rs1_select), (instr >> 15) & 32'h1f,
                        $sformatf("rs1_select[%0d]", i));
            check_value(32'(rs2_select), (instr >> 20) & 32'h1f,
                        $sformatf("rs2_select[%0d]", i));
        end
        @(posedge clk);
        #DRIVE_DELAY;
        check_registered(NUM_VECTORS - 1);

        $display("** PASS **");
        $finish;
    end

endmodule

// File: build.f
+incdir+rtl
rtl/decode_pkg.sv
rtl/imm_gen.sv
rtl/ctrl_decode.sv
rtl/decode_stage.sv
test/tb_decode.sv

// File: Makefile
# Verilator flow for the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= build.f
TRACE     ?= test/decode_trace.txt
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(SIM_BIN): $(SOURCES) $(FILELIST) rtl/decode_config.svh
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# Run from the project root so the trace path resolves
sim: $(SIM_BIN) $(TRACE)
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: test/decode_trace.txt
// instr pc next_pc rs1_data rs2_data hazard0 hazard1 stall_in invalidate valid_in
// then expected: stall_out valid_out imm ctrl check_ctrl
123452B7 00001000 00001004 10000000 20000000 00 00 0 0 1 0 1 12345000 CD0004A0 1
FFFFF2B7 00001004 00001008 10000001 20000001 00 00 0 0 1 0 1 FFFFF000 CD0004A0 1
80000297 00001008 0000100C 10000002 20000002 00 00 0 0 1 0 1 80000000 090004A0 1
00001297 0000100C 00001010 10000003 20000003 00 00 0 0 1 0 1 00001000 090004A0 1
008000EF 00001010 00001014 10000004 20000004 00 00 0 0 1 0 1 00000008 09060C20 1
FFDFF0EF 00001014 00001018 10000005 20000005 00 00 0 0 1 0 1 FFFFFFFC 09060C20 1
010100E7 00001018 0000101C 10000006 20000006 00 00 0 0 1 0 1 00000010 01060C20 1
FFF100E7 0000101C 00001020 10000007 20000007 00 00 0 0 1 0 1 FFFFFFFF 01060C20 1
00208863 00001020 00001024 10000008 20000008 00 00 0 0 1 0 1 00000010 09020000 1
FE20ECE3 00001024 00001028 10000009 20000009 00 00 0 0 1 0 1 FFFFFFF8 09320000 1
FFC12283 00001028 0000102C 1000000A 2000000A 00 00 0 0 1 0 1 FFFFFFFC 010158A0 1
00814283 0000102C 00001030 1000000B 2000000B 00 00 0 0 1 0 1 00000008 010108A0 1
0020A623 00001030 00001034 1000000C 2000000C 00 00 0 0 1 0 1 0000000C 0100C000 1
FE208FA3 00001034 00001038 1000000D 2000000D 00 00 0 0 1 0 1 FFFFFFFF 01008000 1
FFE08293 00001038 0000103C 1000000E 2000000E 00 00 0 0 1 0 1 FFFFFFFE 010004A0 1
40305293 0000103C 00001040 1000000F 2000000F 00 00 0 0 1 0 1 00000403 B10004A0 1
4000C293 00001040 00001044 10000010 20000010 00 00 0 0 1 0 1 00000400 810004A0 1
402082B3 00001044 00001048 10000011 20000011 00 00 0 0 1 0 1 00000000 100004A0 1
0020B2B3 00001048 0000104C 10000012 20000012 00 00 0 0 1 0 1 00000000 600004A0 1
0FF0000F 0000104C 00001050 10000013 20000013 00 00 0 0 1 0 1 00000000 00000000 1
010110E7 00001050 00001054 10000014 20000014 00 00 0 0 1 0 1 00000010 00000012 1
0020A863 00001054 00001058 10000015 20000015 00 00 0 0 1 0 1 00000010 00000012 1
FFC13283 00001058 0000105C 10000016 20000016 00 00 0 0 1 0 1 FFFFFFFC 00000012 1
00816283 0000105C 00001060 10000017 20000017 00 00 0 0 1 0 1 00000008 00000012 1
0020B623 00001060 00001064 10000018 20000018 00 00 0 0 1 0 1 0000000C 00000012 1
0020C623 00001064 00001068 10000019 20000019 00 00 0 0 1 0 1 0000000C 00000012 1
022082B3 00001068 0000106C 1000001A 2000001A 00 00 0 0 1 0 1 00000000 00000012 1
402092B3 0000106C 00001070 1000001B 2000001B 00 00 0 0 1 0 1 00000000 00000012 1
0000100F 00001070 00001074 1000001C 2000001C 00 00 0 0 1 0 1 00000000 00000012 1
0000007F 00001074 00001078 1000001D 2000001D 00 00 0 0 1 0 1 00000000 00000012 1
00000073 00001078 0000107C 1000001E 2000001E 00 00 0 0 1 0 1 00000000 0000001B 1
00100073 0000107C 00001080 1000001F 2000001F 00 00 0 0 1 0 1 00000000 00000013 1
30200073 00001080 00001084 10000020 20000020 00 00 0 0 1 0 1 00000000 00000012 1
002082B3 00001084 00001088 10000021 20000021 02 00 0 0 1 1 0 00000000 00000012 1
002082B3 00001084 00001088 10000021 20000021 00 01 0 0 1 1 0 00000000 00000012 1
00700293 00001088 0000108C 10000022 20000022 00 03 0 0 1 0 1 00000007 010004A0 1
123452B7 0000108C 00001090 10000023 20000023 00 00 1 0 1 0 1 00000007 010004A0 1
123452B7 0000108C 00001090 10000023 20000023 00 00 1 0 1 0 1 00000007 010004A0 1
123452B7 0000108C 00001090 10000023 20000023 00 00 1 0 1 0 1 00000007 010004A0 1
123452B7 0000108C 00001090 10000023 20000023 00 00 0 0 1 0 1 12345000 CD0004A0 1
00700293 00001090 00001094 10000024 20000024 00 00 0 1 1 0 0 12345000 CD0004A0 1
00700293 00001090 00001094 10000024 20000024 00 00 0 0 0 0 0 12345000 CD0004A0 1
00700293 00001090 00001094 10000024 20000024 00 00 1 0 0 0 0 12345000 CD0004A0 1
00000073 00001094 00001098 10000025 20000025 00 00 0 0 1 0 1 00000000 0000001B 1
